// ==== design/fl_cfg.svh ====
`ifndef FL_CFG_SVH
`define FL_CFG_SVH

// buffer geometry
`define FL_NUMADDR 64
`define FL_WIDTH 16
`define FL_NUMWRDS 4

// first back-pressure threshold
`define FL_BP_DEFAULT 8

`endif

// ==== design/fl_pkg.sv ====
`include "fl_cfg.svh"

package fl_pkg;

  localparam int ADDR_W  = $clog2(`FL_NUMADDR);
  localparam int WRD_W   = $clog2(`FL_NUMWRDS);
  localparam int ROW_W   = ADDR_W - WRD_W;        // physical row index bits
  localparam int NUMROWS = `FL_NUMADDR / `FL_NUMWRDS;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [WRD_W-1:0]     wrd_t;
  typedef logic [ROW_W-1:0]     ridx_t;
  typedef logic [`FL_WIDTH-1:0] data_t;

  // word 0 sits in the low bits of the row
  typedef data_t [`FL_NUMWRDS-1:0] row_t;

  // must reach `FL_NUMADDR itself
  typedef logic [$clog2(`FL_NUMADDR+1)-1:0] count_t;

  typedef struct packed {
    data_t data;
  } alloc_req_t;

  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } rd_rsp_t;

  typedef struct packed {
    addr_t addr;
  } free_req_t;

endpackage

// ==== design/mem_1r1w.sv ====
`timescale 1ns/10ps
`include "fl_cfg.svh"

module mem_1r1w #(
  parameter type T     = logic,
  parameter int  DEPTH = `FL_NUMADDR
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  T                         wdata,
  input  logic                     re,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output T                         rdata
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, same-entry collision returns the old value
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];   // holds while re is low
    end
  end

endmodule

// ==== design/free_list.sv ====
`timescale 1ns/10ps
`include "fl_cfg.svh"

module free_list (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push,
  input  fl_pkg::addr_t  push_addr,
  input  logic           pop,
  output logic           head_valid,
  output fl_pkg::addr_t  head_addr,
  output fl_pkg::count_t count
);

  fl_pkg::addr_t  wr_ptr;
  fl_pkg::addr_t  rd_ptr;
  fl_pkg::count_t mem_cnt;     // entries behind the head
  fl_pkg::addr_t  byp_addr;
  fl_pkg::addr_t  mem_rdata;
  logic           use_mem;
  logic           head_free;
  logic           bypass;
  logic           mem_we;
  logic           mem_re;

  // head slot is open when empty or taken this cycle
  assign head_free = !head_valid || pop;

  // push into an empty list goes straight to the head
  assign bypass = head_free && push && (mem_cnt == '0);
  assign mem_re = head_free && (mem_cnt != '0);
  assign mem_we = push && !bypass;

  mem_1r1w #(
    .T     (fl_pkg::addr_t),
    .DEPTH (`FL_NUMADDR)
  ) u_mem (
    .clk   (clk),
    .we    (mem_we),
    .waddr (wr_ptr),
    .wdata (push_addr),
    .re    (mem_re),
    .raddr (rd_ptr),
    .rdata (mem_rdata)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      mem_cnt    <= '0;
      count      <= '0;
      head_valid <= 1'b0;
      use_mem    <= 1'b0;
    end else begin
      if (mem_we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_re) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      mem_cnt <= mem_cnt + fl_pkg::count_t'(mem_we) - fl_pkg::count_t'(mem_re);
      count   <= count + fl_pkg::count_t'(push) - fl_pkg::count_t'(pop);
      if (bypass || mem_re) begin
        head_valid <= 1'b1;
        use_mem    <= mem_re;   // refill comes out of the memory read register
      end else if (pop) begin
        head_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bypass) begin
      byp_addr <= push_addr;
    end
  end

  assign head_addr = use_mem ? mem_rdata : byp_addr;

endmodule

// ==== design/row_align.sv ====
`timescale 1ns/10ps
`include "fl_cfg.svh"

module row_align (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            en,
  input  logic            wr,
  input  fl_pkg::addr_t   wr_addr,
  input  fl_pkg::data_t   wr_data,
  input  logic            rd_valid,
  input  fl_pkg::rd_req_t rd_req,
  output logic            rd_ready,
  output logic            rsp_valid,
  output fl_pkg::rd_rsp_t rsp,
  input  logic            rsp_ready
);

  fl_pkg::ridx_t          wr_row;
  fl_pkg::wrd_t           wr_wrd;
  fl_pkg::ridx_t          rd_row_idx;
  logic [`FL_NUMWRDS-1:0] wmask;
  fl_pkg::row_t           rd_row;
  logic                   rd_fire;
  logic                   s1_valid;    // memory stage
  fl_pkg::addr_t          s1_addr;
  logic                   s1_adv;

  // upper bits pick the physical row, lower bits the word in it
  assign wr_row     = wr_addr[fl_pkg::ADDR_W-1:fl_pkg::WRD_W];
  assign wr_wrd     = wr_addr[fl_pkg::WRD_W-1:0];
  assign rd_row_idx = rd_req.addr[fl_pkg::ADDR_W-1:fl_pkg::WRD_W];

  always_comb begin
    wmask         = '0;
    wmask[wr_wrd] = wr;
  end

  // one bank per word lane, all lanes share the row address
  for (genvar w = 0; w < `FL_NUMWRDS; w++) begin : g_lane
    mem_1r1w #(
      .T     (fl_pkg::data_t),
      .DEPTH (fl_pkg::NUMROWS)
    ) u_mem (
      .clk   (clk),
      .we    (wmask[w]),
      .waddr (wr_row),
      .wdata (wr_data),
      .re    (rd_fire),
      .raddr (rd_row_idx),
      .rdata (rd_row[w])
    );
  end

  // memory stage moves on when the output slot is free or draining
  assign s1_adv   = s1_valid && (!rsp_valid || rsp_ready);
  assign rd_ready = en && (!s1_valid || s1_adv);
  assign rd_fire  = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (rd_fire) begin
        s1_valid <= 1'b1;
      end else if (s1_adv) begin
        s1_valid <= 1'b0;
      end
      if (s1_adv) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      s1_addr <= rd_req.addr;
    end
    if (s1_adv) begin
      rsp.addr <= s1_addr;
      rsp.data <= rd_row[s1_addr[fl_pkg::WRD_W-1:0]];   // word index rides along
    end
  end

endmodule

// ==== design/fl_ctrl.sv ====
`timescale 1ns/10ps
`include "fl_cfg.svh"

module fl_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alloc_valid,
  input  fl_pkg::alloc_req_t alloc_req,
  output logic               alloc_ready,
  output fl_pkg::addr_t      alloc_addr,
  input  logic               free_valid,
  input  fl_pkg::free_req_t  free_req,
  output logic               free_ready,
  input  fl_pkg::count_t     bp_thr,
  output logic               ready,
  output logic               bp,
  output logic               free_err,
  output logic               fl_push,
  output fl_pkg::addr_t      fl_push_addr,
  output logic               fl_pop,
  input  logic               head_valid,
  input  fl_pkg::addr_t      head_addr,
  input  fl_pkg::count_t     count,
  output logic               wr,
  output fl_pkg::addr_t      wr_addr,
  output fl_pkg::data_t      wr_data,
  output logic               en
);

  fl_pkg::addr_t          init_addr;
  logic [`FL_NUMADDR-1:0] alloc_map;   // one bit per address, set while allocated
  logic                   alloc_fire;
  logic                   free_fire;
  logic                   free_ok;

  assign alloc_ready = ready && head_valid;
  assign alloc_addr  = head_addr;
  assign alloc_fire  = alloc_valid && alloc_ready;

  assign free_ready = ready;
  assign free_fire  = free_valid && free_ready;
  assign free_ok    = alloc_map[free_req.addr];

  // init owns the push port until ready
  assign fl_push      = !ready || (free_fire && free_ok);
  assign fl_push_addr = ready ? free_req.addr : init_addr;
  assign fl_pop       = alloc_fire;

  // allocation writes its word on the accept edge
  assign wr      = alloc_fire;
  assign wr_addr = head_addr;
  assign wr_data = alloc_req.data;

  assign en = ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready     <= 1'b0;
      init_addr <= '0;
      alloc_map <= '0;
      bp        <= 1'b0;
      free_err  <= 1'b0;
    end else begin
      if (!ready) begin
        init_addr <= init_addr + 1'b1;
        if (init_addr == fl_pkg::addr_t'(`FL_NUMADDR - 1)) begin
          ready <= 1'b1;   // last address pushed
        end
      end

      // head address is always free, so set and clear never collide
      if (alloc_fire) begin
        alloc_map[head_addr] <= 1'b1;
      end
      if (free_fire && free_ok) begin
        alloc_map[free_req.addr] <= 1'b0;
      end

      free_err <= free_fire && !free_ok;
      bp       <= ready && (count < bp_thr);
    end
  end

endmodule

// ==== design/fl_mem_top.sv ====
`timescale 1ns/10ps
`include "fl_cfg.svh"

module fl_mem_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alloc_valid,
  input  fl_pkg::alloc_req_t alloc_req,
  output logic               alloc_ready,
  output fl_pkg::addr_t      alloc_addr,
  input  logic               rd_valid,
  input  fl_pkg::rd_req_t    rd_req,
  output logic               rd_ready,
  output logic               rsp_valid,
  output fl_pkg::rd_rsp_t    rsp,
  input  logic               rsp_ready,
  input  logic               free_valid,
  input  fl_pkg::free_req_t  free_req,
  output logic               free_ready,
  input  fl_pkg::count_t     bp_thr,
  output logic               ready,
  output logic               bp,
  output logic               free_err
);

  logic           fl_push;
  fl_pkg::addr_t  fl_push_addr;
  logic           fl_pop;
  logic           head_valid;
  fl_pkg::addr_t  head_addr;
  fl_pkg::count_t count;
  logic           wr;
  fl_pkg::addr_t  wr_addr;
  fl_pkg::data_t  wr_data;
  logic           en;

  fl_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_valid  (alloc_valid),
    .alloc_req    (alloc_req),
    .alloc_ready  (alloc_ready),
    .alloc_addr   (alloc_addr),
    .free_valid   (free_valid),
    .free_req     (free_req),
    .free_ready   (free_ready),
    .bp_thr       (bp_thr),
    .ready        (ready),
    .bp           (bp),
    .free_err     (free_err),
    .fl_push      (fl_push),
    .fl_push_addr (fl_push_addr),
    .fl_pop       (fl_pop),
    .head_valid   (head_valid),
    .head_addr    (head_addr),
    .count        (count),
    .wr           (wr),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .en           (en)
  );

  free_list u_free_list (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (fl_push),
    .push_addr  (fl_push_addr),
    .pop        (fl_pop),
    .head_valid (head_valid),
    .head_addr  (head_addr),
    .count      (count)
  );

  // reads bypass the control block
  row_align u_row_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .wr        (wr),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_valid  (rd_valid),
    .rd_req    (rd_req),
    .rd_ready  (rd_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready)
  );

endmodule

// ==== verification/fl_mem_checks.sv ====
`timescale 1ns/10ps
`include "fl_cfg.svh"

module fl_mem_checks (
  input logic            clk,
  input logic            rst_n,
  input logic            ready,
  input logic            alloc_valid,
  input logic            alloc_ready,
  input fl_pkg::addr_t   alloc_addr,
  input logic            rd_valid,
  input logic            rd_ready,
  input logic            rsp_valid,
  input fl_pkg::rd_rsp_t rsp,
  input logic            rsp_ready,
  input logic            free_ready,
  input logic            bp,
  input logic            free_err,
  input logic            fast_mode,
  input logic            exp_empty,
  input fl_pkg::addr_t   exp_alloc_addr,
  input logic            exp_rd_ready,
  input logic            exp_bp,
  input logic            exp_free_err,
  input fl_pkg::rd_rsp_t exp_rsp
);

  int              cyc;
  int              err_init  = 0;
  int              err_alloc = 0;
  int              err_read  = 0;
  int              err_bp    = 0;
  int              err_free  = 0;
  logic [1:0]      fire_d;      // read accepts, one and two cycles back
  logic            hold;        // response stalled last cycle
  fl_pkg::rd_rsp_t rsp_q;

  always @(posedge clk) begin
    if (!rst_n) begin
      cyc    <= 0;
      fire_d <= '0;
      hold   <= 1'b0;
    end else begin
      cyc    <= cyc + 1;
      fire_d <= {fire_d[0], rd_valid && rd_ready};
      hold   <= rsp_valid && !rsp_ready;
      rsp_q  <= rsp;

      // init pushes one address per cycle, ready follows the last push
      assert (ready == (cyc >= `FL_NUMADDR)) else begin
        $display("FAILED %0t ready expected %0b got %0b", $time, cyc >= `FL_NUMADDR, ready);
        err_init++;
      end
      assert (free_ready == (cyc >= `FL_NUMADDR)) else begin
        $display("FAILED %0t free_ready expected %0b got %0b", $time, cyc >= `FL_NUMADDR,
                 free_ready);
        err_free++;
      end
      assert (alloc_ready == !exp_empty) else begin
        $display("FAILED %0t alloc_ready expected %0b got %0b", $time, !exp_empty, alloc_ready);
        err_alloc++;
      end
      assert (!(alloc_valid && alloc_ready && !exp_empty) || alloc_addr == exp_alloc_addr)
      else begin
        $display("FAILED %0t alloc_addr expected %0d got %0d", $time, exp_alloc_addr,
                 alloc_addr);
        err_alloc++;
      end
      assert (bp == exp_bp) else begin
        $display("FAILED %0t bp expected %0b got %0b", $time, exp_bp, bp);
        err_bp++;
      end
      assert (free_err == exp_free_err) else begin
        $display("FAILED %0t free_err expected %0b got %0b", $time, exp_free_err, free_err);
        err_free++;
      end
      assert (rd_ready == exp_rd_ready) else begin
        $display("FAILED %0t rd_ready expected %0b got %0b", $time, exp_rd_ready, rd_ready);
        err_read++;
      end
      assert (!(rsp_valid && rsp_ready) || rsp == exp_rsp) else begin
        $display("FAILED %0t rsp expected %h got %h", $time, exp_rsp, rsp);
        err_read++;
      end
      assert (!fast_mode || rsp_valid == fire_d[1]) else begin
        $display("FAILED %0t rsp_valid expected %0b got %0b", $time, fire_d[1], rsp_valid);
        err_read++;
      end
      assert (!hold || (rsp_valid && rsp == rsp_q)) else begin
        $display("FAILED %0t rsp expected %h got %h (held)", $time, rsp_q, rsp);
        err_read++;
      end
    end
  end

endmodule

// ==== verification/fl_mem_tb.sv ====
`timescale 1ns/10ps
`include "fl_cfg.svh"

module fl_mem_tb;

  localparam int PERIOD   = 8;
  localparam int N_OPS    = 600;
  localparam int INIT_CYC = 8 + `FL_NUMADDR + 1;   // reset plus free-list load

  logic               clk = 1'b0;
  logic               rst_n;
  logic               alloc_valid;
  fl_pkg::alloc_req_t alloc_req;
  logic               alloc_ready;
  fl_pkg::addr_t      alloc_addr;
  logic               rd_valid;
  fl_pkg::rd_req_t    rd_req;
  logic               rd_ready;
  logic               rsp_valid;
  fl_pkg::rd_rsp_t    rsp;
  logic               rsp_ready;
  logic               free_valid;
  fl_pkg::free_req_t  free_req;
  logic               free_ready;
  fl_pkg::count_t     bp_thr;
  logic               ready;
  logic               bp;
  logic               free_err;

  // expected values for the coming rising edge
  logic               fast_mode;
  logic               exp_empty;
  fl_pkg::addr_t      exp_alloc_addr;
  logic               exp_rd_ready;
  logic               exp_bp;
  logic               exp_free_err;
  fl_pkg::rd_rsp_t    exp_rsp;

  // reference model
  fl_pkg::addr_t      fq[$];          // free addresses, oldest first
  fl_pkg::rd_rsp_t    rq[$];          // reads in flight
  fl_pkg::data_t      mdata[`FL_NUMADDR];
  bit                 amap[`FL_NUMADDR];
  bit                 written[`FL_NUMADDR];
  logic               bp_next;
  logic               err_next;
  int                 other_err = 0;
  logic [31:0]        lfsr = 32'h6989_77eb;

  fl_mem_top UUT (.*);

  fl_mem_checks u_checks (.*);

  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    repeat (n) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // one clock of stimulus, entered and left on a falling edge
  task automatic do_cycle(input bit try_alloc, input bit try_free, input bit try_read,
                          input bit slow, input bit lat);
    fl_pkg::addr_t ra;
    fl_pkg::addr_t fa;
    fl_pkg::addr_t head;
    bit            free_ok;
    ra   = fl_pkg::addr_t'(rand_bits(fl_pkg::ADDR_W));
    fa   = fl_pkg::addr_t'(rand_bits(fl_pkg::ADDR_W));
    head = (fq.size() != 0) ? fq[0] : '0;
    alloc_valid    = try_alloc;
    // low bits carry the address, so every word differs
    alloc_req.data = (fl_pkg::data_t'(rand_bits(`FL_WIDTH)) << fl_pkg::ADDR_W)
                     | fl_pkg::data_t'(head);
    free_valid     = try_free;
    free_req.addr  = fa;
    rd_valid       = try_read && written[ra];
    rd_req.addr    = ra;
    rsp_ready      = slow ? (rand_bits(1) != 0) : 1'b1;
    fast_mode      = lat;
    #1;
    exp_empty      = (fq.size() == 0);
    exp_alloc_addr = head;
    exp_bp         = bp_next;
    exp_free_err   = err_next;
    bp_next        = fl_pkg::count_t'(fq.size()) < bp_thr;
    // two reads fill the memory stage and the output register
    exp_rd_ready   = (rq.size() < 2) || rsp_ready;
    if (rsp_valid && rsp_ready) begin
      if (rq.size() == 0) begin
        $display("%0t: response delivered with no read outstanding", $time);
        other_err++;
      end else begin
        exp_rsp = rq.pop_front();
      end
    end
    if (rd_valid && rd_ready) begin
      rq.push_back(fl_pkg::rd_rsp_t'({ra, mdata[ra]}));   // old data on a same-cycle write
    end
    free_ok  = free_valid && free_ready && amap[fa];
    err_next = free_valid && free_ready && !amap[fa];
    if (alloc_valid && alloc_ready) begin
      if (fq.size() == 0) begin
        $display("%0t: allocation accepted while the model free list is empty", $time);
        other_err++;
      end else begin
        void'(fq.pop_front());
        amap[head]    = 1'b1;
        mdata[head]   = alloc_req.data;
        written[head] = 1'b1;
      end
    end
    if (free_ok) begin
      amap[fa] = 1'b0;
      fq.push_back(fa);
    end
    @(negedge clk);
  endtask

  task automatic run_phase(input int cycles, input int thr, input bit slow,
                           input int p_alloc, input int p_free, input int p_read);
    bit a;
    bit f;
    bit r;
    bp_thr = fl_pkg::count_t'(thr);
    repeat (cycles) begin
      a = rand_bits(2) < p_alloc;   // chance out of four
      f = rand_bits(2) < p_free;
      r = rand_bits(2) < p_read;
      do_cycle(a, f, r, slow, !slow);
    end
  endtask

  // let every read complete before the latency check comes back on
  task automatic drain();
    int idle;
    idle = 0;
    while (rq.size() != 0 || idle < 3) begin
      if (rq.size() == 0) begin
        idle++;
      end
      do_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
  endtask

  initial begin
    int i;
    int total;
    rst_n          = 1'b0;
    alloc_valid    = 1'b0;
    alloc_req      = '0;
    rd_valid       = 1'b0;
    rd_req         = '0;
    rsp_ready      = 1'b1;
    free_valid     = 1'b0;
    free_req       = '0;
    bp_thr         = `FL_BP_DEFAULT;
    fast_mode      = 1'b0;
    exp_empty      = 1'b1;
    exp_alloc_addr = '0;
    exp_rd_ready   = 1'b0;
    exp_bp         = 1'b0;
    exp_free_err   = 1'b0;
    exp_rsp        = '0;
    bp_next        = 1'b0;
    err_next       = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    while (!ready) begin
      @(negedge clk);
    end
    for (i = 0; i < `FL_NUMADDR; i++) begin
      fq.push_back(fl_pkg::addr_t'(i));
    end
    run_phase(80, `FL_BP_DEFAULT, 1'b0, 4, 0, 2);   // drain the free list dry
    run_phase(200, 33, 1'b0, 2, 3, 3);
    drain();
    run_phase(200, `FL_NUMADDR, 1'b1, 2, 2, 4);     // stalled responses
    drain();
    run_phase(120, 0, 1'b0, 1, 3, 2);
    drain();
    total = u_checks.err_init + u_checks.err_alloc + u_checks.err_read + u_checks.err_bp
            + u_checks.err_free + other_err;
    $display("errors: init %0d, alloc %0d, read %0d, bp %0d, free_err %0d, other %0d",
             u_checks.err_init, u_checks.err_alloc, u_checks.err_read, u_checks.err_bp,
             u_checks.err_free, other_err);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #((INIT_CYC + N_OPS * 8) * PERIOD);
    $display("timeout: run did not end within %0d cycles", INIT_CYC + N_OPS * 8);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+design
design/fl_pkg.sv
design/mem_1r1w.sv
design/free_list.sv
design/row_align.sv
design/fl_ctrl.sv
design/fl_mem_top.sv
verification/fl_mem_checks.sv
verification/fl_mem_tb.sv

// ==== Bender.yml ====
package:
  name: fl_mem

sources:
  - include_dirs:
      - design
    files:
      - design/fl_pkg.sv
      - design/mem_1r1w.sv
      - design/free_list.sv
      - design/row_align.sv
      - design/fl_ctrl.sv
      - design/fl_mem_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/fl_mem_checks.sv
      - verification/fl_mem_tb.sv
